// ==== test/exe_stage_tests.txt ====
# name valid inst pc rn_data rm_data rn_a rm_a rd_a wb_en wb_a wb_data flush
#   then expected: valid write data flags branch target flush (all hex)
and_imm 1 E20000FF 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 F0 0 0 0 0
eor_lsl4 1 E0200200 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 FF0 0 0 0 0
sub_lsr4 1 E0400220 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 EFF1 0 0 0 0
rsb_imm_rot 1 E2600101 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 3FFF0F10 0 0 0 0
add_asr4 1 E0800240 0 F0F0 80000000 1 2 F 0 0 0 0 1 1 F800F0F0 0 0 0 0
adc_ror8 1 E0A00460 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 F000F0FF 0 0 0 0
sbc_imm 1 E2C00010 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 F0DF 0 0 0 0
rsc_lsl0 1 E0E00000 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 FFFF1EFF 0 0 0 0
orr_lsr32 1 E1800020 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 F0F0 0 0 0 0
mov_asr32 1 E1A00040 0 F0F0 80000000 1 2 F 0 0 0 0 1 1 FFFFFFFF 0 0 0 0
bic_imm 1 E3C000F0 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 F000 0 0 0 0
mvn_rrx 1 E1E00060 0 F0F0 FF0 1 2 F 0 0 0 0 1 1 FFFFF807 0 0 0 0
cmp_eq 1 E3500010 0 10 0 1 2 F 0 0 0 0 1 0 0 6 0 0 0
cmn_ovf 1 E3700001 0 7FFFFFFF 0 1 2 F 0 0 0 0 1 0 0 9 0 0 0
tst_lsl1 1 E1100080 0 2 80000001 1 2 F 0 0 0 0 1 0 0 3 0 0 0
teq_imm 1 E33000FF 0 FF 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_ne 1 12900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_cc 1 32900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_mi 1 42900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_vc 1 72900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_hi 1 82900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_ge 1 A2900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_gt 1 C2900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
fail_nv 1 F2900001 0 1 0 1 2 F 0 0 0 0 1 0 0 7 0 0 0
pass_ls 1 92900001 0 1 0 1 2 F 0 0 0 0 1 1 2 0 0 0 0
fail_eq 1 02900001 0 1 0 1 2 F 0 0 0 0 1 0 0 0 0 0 0
fail_cs 1 22900001 0 1 0 1 2 F 0 0 0 0 1 0 0 0 0 0 0
fail_vs 1 62900001 0 1 0 1 2 F 0 0 0 0 1 0 0 0 0 0 0
fail_lt 1 B2900001 0 1 0 1 2 F 0 0 0 0 1 0 0 0 0 0 0
fail_le 1 D2900001 0 1 0 1 2 F 0 0 0 0 1 0 0 0 0 0 0
fwd_set 1 E3A00055 0 0 0 1 2 3 0 0 0 0 1 1 55 0 0 0 0
fwd_prev_rn 1 E0800000 0 1 1 3 2 4 0 0 0 0 1 1 56 0 0 0 0
fwd_wb_rm 1 E0800000 0 1 9 1 4 5 1 4 100 0 1 1 101 0 0 0 0
fwd_prev_rm 1 E0800000 0 1 0 1 5 6 0 0 0 0 1 1 102 0 0 0 0
fwd_wb_rn 1 E0800000 0 0 1 6 2 F 1 6 200 0 1 1 201 0 0 0 0
br_taken 1 EA000010 100 0 0 1 2 F 0 0 0 0 1 0 0 0 1 148 0
shadow_1 1 E2800001 0 1 0 1 2 F 0 0 0 0 0 0 0 0 0 0 1
shadow_2 1 E2800001 0 1 0 1 2 F 0 0 0 0 0 0 0 0 0 0 1
br_after 1 E3A00007 0 0 0 1 2 F 0 0 0 0 1 1 7 0 0 0 0
flush_in 1 E2900001 0 7FFFFFFF 0 1 2 F 0 0 0 1 0 0 0 0 0 0 0
br_not_taken 1 0A000010 200 0 0 1 2 F 0 0 0 0 1 0 0 0 0 0 0
after_nt 1 E3A00007 0 0 0 1 2 F 0 0 0 0 1 1 7 0 0 0 0

// ==== exe_stage.f ====
+incdir+rtl
rtl/exe_pkg.sv
rtl/operand_shifter.sv
rtl/exe_alu.sv
rtl/squash_fsm.sv
rtl/shadow_counter.sv
rtl/exe_stage.sv
test/exe_stage_chk.sv
test/exe_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing --assert -Wno-fatal \
  --top-module exe_stage_tb -f exe_stage.f -o exe_stage_sim &&
  ./obj_dir/exe_stage_sim | tee /dev/stderr | grep -qF '*** PASSED ***' &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }

// ==== test/exe_stage_tb.sv ====
`timescale 1ns/1ps

module exe_stage_tb;

  localparam int MAX_LINES  = 64;
  localparam int NUM_FIELDS = 19;

  // DUT inputs
  logic               clk_i;
  logic               arst_n_i;
  logic               valid_i;
  exe_pkg::inst_t     inst_i;
  exe_pkg::word_t     pc_i;
  exe_pkg::word_t     rn_data_i;
  exe_pkg::word_t     rm_data_i;
  exe_pkg::reg_addr_t rn_addr_i;
  exe_pkg::reg_addr_t rm_addr_i;
  exe_pkg::reg_addr_t rd_addr_i;
  logic               wb_en_i;
  exe_pkg::reg_addr_t wb_addr_i;
  exe_pkg::word_t     wb_data_i;
  logic               flush_i;
  // DUT outputs
  logic               valid_o;
  exe_pkg::word_t     alu_data_o;
  exe_pkg::reg_addr_t rd_addr_o;
  logic               do_write_o;
  exe_pkg::flags_t    flags_o;
  logic               branch_o;
  exe_pkg::word_t     target_o;
  logic               flush_o;

  // Test table with one row per cycle
  logic [8*16-1:0] names [MAX_LINES];
  logic [31:0]     fields [MAX_LINES][NUM_FIELDS];
  int              num_lines;
  logic            loaded;

  exe_stage i_dut (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .valid_i    (valid_i),
    .inst_i     (inst_i),
    .pc_i       (pc_i),
    .rn_data_i  (rn_data_i),
    .rm_data_i  (rm_data_i),
    .rn_addr_i  (rn_addr_i),
    .rm_addr_i  (rm_addr_i),
    .rd_addr_i  (rd_addr_i),
    .wb_en_i    (wb_en_i),
    .wb_addr_i  (wb_addr_i),
    .wb_data_i  (wb_data_i),
    .flush_i    (flush_i),
    .valid_o    (valid_o),
    .alu_data_o (alu_data_o),
    .rd_addr_o  (rd_addr_o),
    .do_write_o (do_write_o),
    .flags_o    (flags_o),
    .branch_o   (branch_o),
    .target_o   (target_o),
    .flush_o    (flush_o)
  );

  // 10 ns clock
  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_val(input logic [8*16-1:0] name, input string what,
                           input logic [31:0] exp_val, input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("MISMATCH %0s %0s expected %h actual %h", name, what, exp_val, act_val);
      $display("*** FAILED ***");
      $fatal(1, "output check failed");
    end
  endtask

  // Fills the table and skips lines that start with #
  task automatic load_tests();
    int              fd;
    int              cnt;
    string           line;
    logic [8*16-1:0] nm;
    logic [31:0]     v [NUM_FIELDS];
    num_lines = 0;
    fd = $fopen("test/exe_stage_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the tests file");
      $display("*** FAILED ***");
      $fatal(1, "missing tests file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      cnt = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    nm, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18]);
      if (cnt != NUM_FIELDS + 1 || num_lines >= MAX_LINES) begin
        $display("Malformed or surplus line in the tests file: %0s", line);
        $display("*** FAILED ***");
        $fatal(1, "bad tests file");
      end
      names[num_lines] = nm;
      for (int k = 0; k < NUM_FIELDS; k++) begin
        fields[num_lines][k] = v[k];
      end
      num_lines++;
    end
    $fclose(fd);
  endtask

  // Inputs for one row applied on the rising edge
  task automatic drive_line(input int i);
    valid_i   <= fields[i][0][0];
    inst_i    <= fields[i][1];
    pc_i      <= fields[i][2];
    rn_data_i <= fields[i][3];
    rm_data_i <= fields[i][4];
    rn_addr_i <= fields[i][5][3:0];
    rm_addr_i <= fields[i][6][3:0];
    rd_addr_i <= fields[i][7][3:0];
    wb_en_i   <= fields[i][8][0];
    wb_addr_i <= fields[i][9][3:0];
    wb_data_i <= fields[i][10];
    flush_i   <= fields[i][11][0];
  endtask

  task automatic drive_idle();
    valid_i <= 1'b0;
    wb_en_i <= 1'b0;
    flush_i <= 1'b0;
  endtask

  // Data and destination only matter on a write and target only on a branch
  task automatic check_line(input int i);
    check_val(names[i], "valid_o", fields[i][12], 32'(valid_o));
    check_val(names[i], "do_write_o", fields[i][13], 32'(do_write_o));
    if (fields[i][13][0]) begin
      check_val(names[i], "alu_data_o", fields[i][14], alu_data_o);
      check_val(names[i], "rd_addr_o", 32'(fields[i][7][3:0]), 32'(rd_addr_o));
    end
    check_val(names[i], "flags_o", fields[i][15], 32'(flags_o));
    check_val(names[i], "branch_o", fields[i][16], 32'(branch_o));
    if (fields[i][16][0]) begin
      check_val(names[i], "target_o", fields[i][17], target_o);
    end
    check_val(names[i], "flush_o", fields[i][18], 32'(flush_o));
  endtask

  // ************************************************************************
  // Main sequence
  // ************************************************************************
  initial begin
    arst_n_i  = 1'b0;
    valid_i   = 1'b0;
    inst_i    = '0;
    pc_i      = '0;
    rn_data_i = '0;
    rm_data_i = '0;
    rn_addr_i = '0;
    rm_addr_i = '0;
    rd_addr_i = '0;
    wb_en_i   = 1'b0;
    wb_addr_i = '0;
    wb_data_i = '0;
    flush_i   = 1'b0;
    loaded    = 1'b0;
    load_tests();
    loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    // Control outputs and flags cleared by reset
    check_val("reset", "valid_o", 32'd0, 32'(valid_o));
    check_val("reset", "do_write_o", 32'd0, 32'(do_write_o));
    check_val("reset", "branch_o", 32'd0, 32'(branch_o));
    check_val("reset", "flush_o", 32'd0, 32'(flush_o));
    check_val("reset", "flags_o", 32'd0, 32'(flags_o));
    @(posedge clk_i);
    drive_line(0);
    // Row i is checked while row i+1 is in flight
    for (int i = 0; i < num_lines; i++) begin
      @(posedge clk_i);
      if (i + 1 < num_lines) begin
        drive_line(i + 1);
      end else begin
        drive_idle();
      end
      @(negedge clk_i);
      check_line(i);
    end
    $display("*** PASSED ***");
    $finish;
  end

  // Watchdog sized from the table length
  initial begin
    wait (loaded);
    #(num_lines * 10 + 200);
    $display("Timeout: the run did not finish in time");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== test/exe_stage_chk.sv ====
`timescale 1ns/1ps

module exe_stage_chk (
  input logic clk_i,
  input logic arst_n_i,
  input logic valid_o,
  input logic do_write_o,
  input logic branch_o,
  input logic flush_o
);

  // Taken branch is a single-cycle pulse
  a_branch_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    branch_o |=> !branch_o)
    else $error("branch_o stayed high for more than one cycle");

  // Shadow slots never carry a valid result
  a_flush_no_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_o |-> !valid_o)
    else $error("valid_o high during a flush slot");

  // Writes only from valid results
  a_write_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    do_write_o |-> valid_o)
    else $error("do_write_o high without valid_o");

endmodule

bind exe_stage exe_stage_chk i_chk (
  .clk_i      (clk_i),
  .arst_n_i   (arst_n_i),
  .valid_o    (valid_o),
  .do_write_o (do_write_o),
  .branch_o   (branch_o),
  .flush_o    (flush_o)
);

// ==== rtl/exe_stage.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module exe_stage (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  exe_pkg::inst_t     inst_i,
  input  exe_pkg::word_t     pc_i,
  input  exe_pkg::word_t     rn_data_i,
  input  exe_pkg::word_t     rm_data_i,
  input  exe_pkg::reg_addr_t rn_addr_i,
  input  exe_pkg::reg_addr_t rm_addr_i,
  input  exe_pkg::reg_addr_t rd_addr_i,
  input  logic               wb_en_i,
  input  exe_pkg::reg_addr_t wb_addr_i,
  input  exe_pkg::word_t     wb_data_i,
  input  logic               flush_i,
  output logic               valid_o,
  output exe_pkg::word_t     alu_data_o,
  output exe_pkg::reg_addr_t rd_addr_o,
  output logic               do_write_o,
  output exe_pkg::flags_t    flags_o,
  output logic               branch_o,
  output exe_pkg::word_t     target_o,
  output logic               flush_o
);

  // Decode
  logic [2:0]       inst_class;
  logic             is_dp;
  logic             is_imm;
  logic             is_branch;
  logic             is_compare;
  exe_pkg::alu_op_t opcode;
  // Operands after forwarding
  exe_pkg::word_t   rn_fwd;
  exe_pkg::word_t   rm_fwd;
  exe_pkg::word_t   op2;
  logic             shift_carry;
  exe_pkg::word_t   alu_result;
  // Acceptance and shadow control
  logic             cond_pass;
  logic             discard;
  logic             count_en;
  logic             shadow_done;
  logic             accept;
  logic             exec;
  logic             branch_taken;
  exe_pkg::word_t   branch_off;

  // ************************************************************************
  // Decode
  // ************************************************************************
  assign inst_class = inst_i[27:25];
  assign is_imm     = inst_class == `EXE_CLASS_DP_IMM;
  assign is_dp      = (inst_class == `EXE_CLASS_DP_REG) || is_imm;
  assign is_branch  = inst_class == `EXE_CLASS_BRANCH;
  assign opcode     = exe_pkg::alu_op_t'(inst_i[24:21]);
  // TST, TEQ, CMP, CMN are 10xx
  assign is_compare = inst_i[24:23] == 2'b10;

  // Writeback wins over our own last result, then the register file
  function automatic exe_pkg::word_t fwd_sel(
    input exe_pkg::reg_addr_t src_addr,
    input exe_pkg::word_t     src_data,
    input logic               prev_en,
    input exe_pkg::reg_addr_t prev_addr,
    input exe_pkg::word_t     prev_data
  );
    if (wb_en_i && (wb_addr_i == src_addr)) begin
      return wb_data_i;
    end else if (prev_en && (prev_addr == src_addr)) begin
      return prev_data;
    end
    return src_data;
  endfunction

  always_comb begin
    rn_fwd = fwd_sel(rn_addr_i, rn_data_i, valid_o && do_write_o, rd_addr_o, alu_data_o);
    rm_fwd = fwd_sel(rm_addr_i, rm_data_i, valid_o && do_write_o, rd_addr_o, alu_data_o);
  end

  // ************************************************************************
  // Datapath
  // ************************************************************************
  operand_shifter i_shifter (
    .shift_ctl_i   (inst_i[11:4]),
    .imm_i         (inst_i[11:0]),
    .use_imm_i     (is_imm),
    .rm_i          (rm_fwd),
    .carry_i       (flags_o[1]),
    .op2_o         (op2),
    .shift_carry_o (shift_carry)
  );

  // Flags only move for executed data-processing ops
  exe_alu i_alu (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .op_i          (opcode),
    .rn_i          (rn_fwd),
    .op2_i         (op2),
    .shift_carry_i (shift_carry),
    .cond_i        (inst_i[31:28]),
    .set_flags_i   (inst_i[20]),
    .flag_en_i     (exec && is_dp),
    .result_o      (alu_result),
    .flags_o       (flags_o),
    .cond_pass_o   (cond_pass)
  );

  // Branch shadow
  squash_fsm i_squash (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .branch_taken_i (branch_taken),
    .shadow_done_i  (shadow_done),
    .discard_o      (discard),
    .count_en_o     (count_en)
  );

  shadow_counter i_shadow_cnt (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .count_en_i (count_en),
    .done_o     (shadow_done)
  );

  assign accept       = valid_i && !flush_i && !discard;
  assign exec         = accept && cond_pass;
  assign branch_taken = exec && is_branch;

  // Word offset, sign extended and scaled by four
  assign branch_off = {{6{inst_i[23]}}, inst_i[23:0], 2'b00};

  // ************************************************************************
  // Output registers
  // ************************************************************************
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o    <= 1'b0;
      do_write_o <= 1'b0;
      branch_o   <= 1'b0;
      flush_o    <= 1'b0;
    end else begin
      valid_o    <= accept;
      do_write_o <= exec && is_dp && !is_compare;
      branch_o   <= branch_taken;
      // Lines up with the dropped shadow slots
      flush_o    <= discard;
    end
  end

  // Payload, qualified by the control bits above
  always_ff @(posedge clk_i) begin
    alu_data_o <= alu_result;
    rd_addr_o  <= rd_addr_i;
    target_o   <= pc_i + 32'd8 + branch_off;
  end

endmodule

// ==== rtl/shadow_counter.sv ====
`timescale 1ns/1ps
`include "exe_cfg.svh"

module shadow_counter (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic count_en_i,
  output logic done_o
);

  // Index of the final shadow slot
  localparam logic [`EXE_SHADOW_CNT_W-1:0] LAST_SLOT = `EXE_SHADOW_CNT_W'(`EXE_SHADOW_LEN - 1);

  logic [`EXE_SHADOW_CNT_W-1:0] cnt_q;

  assign done_o = count_en_i && (cnt_q == LAST_SLOT);

  // Wraps to zero on the last slot, ready for the next branch
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (count_en_i) begin
      if (done_o) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== rtl/squash_fsm.sv ====
`timescale 1ns/1ps

module squash_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic branch_taken_i,
  input  logic shadow_done_i,
  output logic discard_o,
  output logic count_en_o
);

  exe_pkg::squash_state_t state_q;
  exe_pkg::squash_state_t state_d;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      exe_pkg::RUN: begin
        // Branches only count while running
        if (branch_taken_i) begin
          state_d = exe_pkg::SQUASH;
        end
      end
      default: begin
        // Back to RUN on the last shadow slot
        if (shadow_done_i) begin
          state_d = exe_pkg::RUN;
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= exe_pkg::RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Drop inputs and advance the slot counter while squashing
  assign discard_o  = state_q == exe_pkg::SQUASH;
  assign count_en_o = state_q == exe_pkg::SQUASH;

endmodule

// ==== rtl/exe_alu.sv ====
`timescale 1ns/1ps

module exe_alu (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  exe_pkg::alu_op_t op_i,
  input  exe_pkg::word_t   rn_i,
  input  exe_pkg::word_t   op2_i,
  input  logic             shift_carry_i,
  input  logic [3:0]       cond_i,
  input  logic             set_flags_i,
  input  logic             flag_en_i,
  output exe_pkg::word_t   result_o,
  output exe_pkg::flags_t  flags_o,
  output logic             cond_pass_o
);

  // Shared adder
  exe_pkg::word_t  add_a;
  exe_pkg::word_t  add_b;
  logic            add_cin;
  logic [32:0]     sum;
  logic            ovf;
  logic            is_arith;
  // Stored and next flags
  exe_pkg::flags_t flags_q;
  exe_pkg::flags_t flags_d;
  logic            n;
  logic            z;
  logic            c;
  logic            v;

  assign n = flags_q[3];
  assign z = flags_q[2];
  assign c = flags_q[1];
  assign v = flags_q[0];

  // ************************************************************************
  // Adder operand selection
  // ************************************************************************
  always_comb begin
    add_a    = rn_i;
    add_b    = op2_i;
    add_cin  = 1'b0;
    is_arith = 1'b1;
    case (op_i)
      exe_pkg::OP_SUB,
      exe_pkg::OP_CMP: begin
        add_b   = ~op2_i;
        add_cin = 1'b1;
      end
      exe_pkg::OP_RSB: begin
        add_a   = op2_i;
        add_b   = ~rn_i;
        add_cin = 1'b1;
      end
      exe_pkg::OP_ADD,
      exe_pkg::OP_CMN: begin
        add_cin = 1'b0;
      end
      exe_pkg::OP_ADC: begin
        add_cin = c;
      end
      exe_pkg::OP_SBC: begin
        add_b   = ~op2_i;
        add_cin = c;
      end
      exe_pkg::OP_RSC: begin
        add_a   = op2_i;
        add_b   = ~rn_i;
        add_cin = c;
      end
      // logical ops leave the adder idle
      default: is_arith = 1'b0;
    endcase
  end

  assign sum = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};
  // Signed overflow when like-signed inputs give an unlike-signed sum
  assign ovf = (add_a[31] == add_b[31]) && (sum[31] != add_a[31]);

  // Result mux, compares still produce a value for the flags
  always_comb begin
    case (op_i)
      exe_pkg::OP_AND,
      exe_pkg::OP_TST: result_o = rn_i & op2_i;
      exe_pkg::OP_EOR,
      exe_pkg::OP_TEQ: result_o = rn_i ^ op2_i;
      exe_pkg::OP_ORR: result_o = rn_i | op2_i;
      exe_pkg::OP_MOV: result_o = op2_i;
      exe_pkg::OP_BIC: result_o = rn_i & ~op2_i;
      exe_pkg::OP_MVN: result_o = ~op2_i;
      default:         result_o = sum[31:0];
    endcase
  end

  // ************************************************************************
  // NZCV register
  // ************************************************************************
  // Logical ops take C from the shifter and hold V
  assign flags_d = {result_o[31],
                    result_o == '0,
                    is_arith ? sum[32] : shift_carry_i,
                    is_arith ? ovf : v};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      flags_q <= '0;
    end else if (flag_en_i && set_flags_i) begin
      flags_q <= flags_d;
    end
  end

  assign flags_o = flags_q;

  // Condition check against flags before this instruction
  always_comb begin
    case (cond_i)
      4'h0:    cond_pass_o = z;
      4'h1:    cond_pass_o = !z;
      4'h2:    cond_pass_o = c;
      4'h3:    cond_pass_o = !c;
      4'h4:    cond_pass_o = n;
      4'h5:    cond_pass_o = !n;
      4'h6:    cond_pass_o = v;
      4'h7:    cond_pass_o = !v;
      4'h8:    cond_pass_o = c && !z;
      4'h9:    cond_pass_o = !c || z;
      4'hA:    cond_pass_o = n == v;
      4'hB:    cond_pass_o = n != v;
      4'hC:    cond_pass_o = !z && (n == v);
      4'hD:    cond_pass_o = z || (n != v);
      4'hE:    cond_pass_o = 1'b1;
      // NV, never executes
      default: cond_pass_o = 1'b0;
    endcase
  end

endmodule

// ==== rtl/operand_shifter.sv ====
`timescale 1ns/1ps

module operand_shifter (
  input  logic [7:0]     shift_ctl_i,
  input  logic [11:0]    imm_i,
  input  logic           use_imm_i,
  input  exe_pkg::word_t rm_i,
  input  logic           carry_i,
  output exe_pkg::word_t op2_o,
  output logic           shift_carry_o
);

  // Register shift fields, inst bits 11:7, 6:5 and 4
  logic [4:0]     amt;
  logic [1:0]     kind;
  logic           reg_amt;
  // Carry source bit positions
  logic [4:0]     lsl_idx;
  logic [4:0]     low_idx;
  // Rotate helpers, doubled words so a part select rotates
  logic [4:0]     rot2;
  logic [63:0]    imm_dbl;
  logic [63:0]    rm_dbl;
  exe_pkg::word_t imm_rot;
  exe_pkg::word_t rm_ror;

  assign amt     = shift_ctl_i[7:3];
  assign kind    = shift_ctl_i[2:1];
  assign reg_amt = shift_ctl_i[0];

  // 32 - amt, and amt - 1, modulo 32
  assign lsl_idx = 5'd0 - amt;
  assign low_idx = amt - 5'd1;

  // Immediate rotates by twice the 4-bit field
  assign rot2    = {imm_i[11:8], 1'b0};
  assign imm_dbl = {24'd0, imm_i[7:0], 24'd0, imm_i[7:0]};
  assign imm_rot = imm_dbl[rot2 +: 32];

  assign rm_dbl  = {rm_i, rm_i};
  assign rm_ror  = rm_dbl[amt +: 32];

  always_comb begin
    // Default is a plain pass of rm with the old carry
    op2_o         = rm_i;
    shift_carry_o = carry_i;
    if (use_imm_i) begin
      op2_o = imm_rot;
      // Unrotated immediates keep C
      if (rot2 != 5'd0) begin
        shift_carry_o = imm_rot[31];
      end
    end else if (!reg_amt) begin
      // Register-specified amounts not in this subset, rm passes through
      case (kind)
        2'b00: begin
          // LSL #0 leaves rm and C alone
          if (amt != 5'd0) begin
            op2_o         = rm_i << amt;
            shift_carry_o = rm_i[lsl_idx];
          end
        end
        2'b01: begin
          // LSR #0 encodes LSR #32
          if (amt == 5'd0) begin
            op2_o         = '0;
            shift_carry_o = rm_i[31];
          end else begin
            op2_o         = rm_i >> amt;
            shift_carry_o = rm_i[low_idx];
          end
        end
        2'b10: begin
          // ASR #0 encodes ASR #32
          if (amt == 5'd0) begin
            op2_o         = {32{rm_i[31]}};
            shift_carry_o = rm_i[31];
          end else begin
            op2_o         = $signed(rm_i) >>> amt;
            shift_carry_o = rm_i[low_idx];
          end
        end
        default: begin
          // ROR #0 is RRX through the carry
          if (amt == 5'd0) begin
            op2_o         = {carry_i, rm_i[31:1]};
            shift_carry_o = rm_i[0];
          end else begin
            op2_o         = rm_ror;
            shift_carry_o = rm_i[low_idx];
          end
        end
      endcase
    end
  end

endmodule

// ==== rtl/exe_pkg.sv ====
`include "exe_cfg.svh"

package exe_pkg;

  // Data word and register index
  typedef logic [`EXE_DATA_W-1:0] word_t;
  typedef logic [`EXE_REG_ADDR_W-1:0] reg_addr_t;

  // Raw instruction word
  typedef logic [`EXE_DATA_W-1:0] inst_t;

  // NZCV, N in bit 3 down to V in bit 0
  typedef logic [3:0] flags_t;

  // Data-processing opcodes, ARM encoding of bits 24:21
  typedef enum logic [3:0] {
    OP_AND = 4'h0,
    OP_EOR = 4'h1,
    OP_SUB = 4'h2,
    OP_RSB = 4'h3,
    OP_ADD = 4'h4,
    OP_ADC = 4'h5,
    OP_SBC = 4'h6,
    OP_RSC = 4'h7,
    OP_TST = 4'h8,
    OP_TEQ = 4'h9,
    OP_CMP = 4'hA,
    OP_CMN = 4'hB,
    OP_ORR = 4'hC,
    OP_MOV = 4'hD,
    OP_BIC = 4'hE,
    OP_MVN = 4'hF
  } alu_op_t;

  // Branch shadow FSM
  typedef enum logic {
    RUN    = 1'b0,
    SQUASH = 1'b1
  } squash_state_t;

endpackage

// ==== rtl/exe_cfg.svh ====
`ifndef EXE_CFG_SVH
`define EXE_CFG_SVH

// Datapath and register index widths
`define EXE_DATA_W 32
`define EXE_REG_ADDR_W 4

// Instruction class in bits 27:25
`define EXE_CLASS_DP_REG 3'b000
`define EXE_CLASS_DP_IMM 3'b001
`define EXE_CLASS_BRANCH 3'b101

// Younger instructions dropped after a taken branch
`define EXE_SHADOW_LEN 2
`define EXE_SHADOW_CNT_W 2

`endif
